//--- build.f
+incdir+common
common/decode_pkg.sv
logic/instr_decoder.sv
issue/issue_control.sv
issue/div_reuse_tracker.sv
logic/operand_builder.sv
logic/decode_issue.sv
testbench/decode_issue_sva.sv
testbench/decode_issue_checker.sv
testbench/decode_issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the decode/issue testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module decode_issue_tb \
    -o decode_issue_sim \
    && ./obj_dir/decode_issue_sim 2>&1 | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

//--- testbench/decode_issue_tb.sv
//////////////////////////////
// Decode and issue testbench
// Random words against the model
//////////////////////////////
`include "decode_params.svh"

module decode_issue_tb;
    import decode_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES  = 5000;
    localparam int TIMEOUT      = (RESET_CYCLES + TEST_CYCLES + 4) * CLK_PERIOD + 400;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  fb_valid;
    instr_word_u           instruction;
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic                  rs1_conflict;
    logic                  rs2_conflict;
    logic [`NUM_UNITS-1:0] unit_ready;
    logic                  id_available;
    logic                  issue_hold;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic                  instruction_issued;
    logic                  rd_write;
    logic [`NUM_UNITS-1:0] unit_issue;
    logic [`NUM_UNITS-1:0] unit_issue_r;
    logic [`XLEN:0]        alu_in1;
    logic [`XLEN:0]        alu_in2;
    logic [4:0]            shift_amount;
    logic [11:0]           ls_offset;
    logic                  ls_load;
    logic                  ls_store;
    logic [1:0]            md_op;
    logic                  div_reuse;
    logic                  illegal_instruction;
    int                    error_count;
    int                    check_count;
    logic [31:0]           rng = 32'd35;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decode_issue i_dut (.*);

    decode_issue_checker i_checker (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////////////////
    // One random word and its side inputs
    task automatic drive_random_inputs();
        logic [31:0] ctl;
        logic [31:0] fld;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic        no_unit;
        rng = xorshift32(rng);
        ctl = rng;
        rng = xorshift32(rng);
        fld = rng;
        no_unit = 1'b0;
        f7 = fld[31:25];
        case (ctl[3:0])
            4'd0: opc = `OPC_LUI;
            4'd1: opc = `OPC_AUIPC;
            4'd2: opc = `OPC_JAL;
            4'd3: opc = `OPC_JALR;
            4'd4: opc = `OPC_BRANCH;
            4'd5: opc = `OPC_LOAD;
            4'd6: opc = `OPC_STORE;
            4'd7: opc = `OPC_ARITH_IMM;
            // No unit takes these, so all units are held not ready
            4'd13: begin
                opc = ctl[4] ? `OPC_FENCE : `OPC_SYSTEM;
                no_unit = 1'b1;
            end
            4'd14: begin
                opc = fld[15:9];
                no_unit = 1'b1;
            end
            default: begin
                opc = `OPC_ARITH;
                f7 = (ctl[5:4] == 2'd0) ? 7'h20 : ((ctl[5:4] == 2'd1) ? 7'h00 : 7'h01);
            end
        endcase
        // Register fields kept in 0..3 so that repeats are common
        instruction = {f7, 3'b000, fld[1:0], 3'b000, fld[3:2], fld[8:6], 3'b000, fld[5:4], opc};
        rng = xorshift32(rng);
        pc = rng;
        rng = xorshift32(rng);
        rs1_data = rng;
        rng = xorshift32(rng);
        rs2_data = rng;
        rs1_conflict = (ctl[8:6] == 3'd0);
        rs2_conflict = (ctl[11:9] == 3'd0);
        fb_valid = (ctl[14:12] != 3'd0);
        id_available = (ctl[17:15] != 3'd0);
        issue_hold = (ctl[20:18] == 3'd0);
        unit_ready = no_unit ? '0 : (ctl[25:21] | ctl[30:26]);
    endtask

    initial begin
        rst = 1'b1;
        fb_valid = 1'b0;
        instruction = '0;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        unit_ready = '0;
        id_available = 1'b0;
        issue_hold = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (TEST_CYCLES) begin
            drive_random_inputs();
            @(negedge clk);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before the random sequence completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- testbench/decode_issue_checker.sv
//////////////////////////////
// Decode stage checker
// Reference model, compare per cycle
//////////////////////////////
`include "decode_params.svh"

module decode_issue_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fb_valid,
    input  decode_pkg::instr_word_u instruction,
    input  logic [`XLEN-1:0]        pc,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic                    rs1_conflict,
    input  logic                    rs2_conflict,
    input  logic [`NUM_UNITS-1:0]   unit_ready,
    input  logic                    id_available,
    input  logic                    issue_hold,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic                    instruction_issued,
    input  logic                    rd_write,
    input  logic [`NUM_UNITS-1:0]   unit_issue,
    input  logic [`NUM_UNITS-1:0]   unit_issue_r,
    input  logic [`XLEN:0]          alu_in1,
    input  logic [`XLEN:0]          alu_in2,
    input  logic [4:0]              shift_amount,
    input  logic [11:0]             ls_offset,
    input  logic                    ls_load,
    input  logic                    ls_store,
    input  logic [1:0]              md_op,
    input  logic                    div_reuse,
    input  logic                    illegal_instruction,
    output int                      error_count,
    output int                      check_count
);

    logic [6:0]            opc;
    logic [2:0]            f3;
    logic [`NUM_UNITS-1:0] exp_need;
    logic                  exp_illegal;
    logic                  exp_writes_rd;
    logic [`XLEN-1:0]      exp_op1;
    logic [`XLEN-1:0]      exp_op2;
    logic [`NUM_UNITS-1:0] exp_issue;
    logic [`NUM_UNITS-1:0] exp_issue_prev;
    logic [4:0]            div_rs1;
    logic [4:0]            div_rs2;
    logic                  div_valid;
    int                    errors = 0;
    int                    checks = 0;

    assign error_count = errors;
    assign check_count = checks;
    // Raw RV32 bit positions
    assign opc = instruction[6:0];
    assign f3 = instruction[14:12];

    ////////////////////////////////
    // Model of unit choice, operands and issue
    always_comb begin
        exp_need = '0;
        exp_illegal = 1'b0;
        exp_writes_rd = 1'b1;
        exp_op1 = rs1_data;
        exp_op2 = rs2_data;
        case (opc)
            `OPC_LUI: begin
                exp_need[`ALU_UNIT] = 1'b1;
                exp_op1 = '0;
                exp_op2 = {instruction.i.imm, instruction.i.rs1, instruction.i.funct3, 12'h000};
            end
            `OPC_AUIPC: begin
                exp_need[`ALU_UNIT] = 1'b1;
                exp_op1 = pc;
                exp_op2 = {instruction.i.imm, instruction.i.rs1, instruction.i.funct3, 12'h000};
            end
            // Link address is pc plus four
            `OPC_JAL, `OPC_JALR: begin
                exp_need[`BRANCH_UNIT] = 1'b1;
                exp_op1 = pc;
                exp_op2 = 32'd4;
            end
            `OPC_BRANCH: begin
                exp_need[`BRANCH_UNIT] = 1'b1;
                exp_writes_rd = 1'b0;
            end
            `OPC_LOAD: begin
                exp_need[`LS_UNIT] = 1'b1;
            end
            `OPC_STORE: begin
                exp_need[`LS_UNIT] = 1'b1;
                exp_writes_rd = 1'b0;
            end
            `OPC_ARITH_IMM: begin
                exp_need[`ALU_UNIT] = 1'b1;
                exp_op2 = {{20{instruction.i.imm[11]}}, instruction.i.imm};
            end
            `OPC_ARITH: begin
                if (!instruction[25]) begin
                    exp_need[`ALU_UNIT] = 1'b1;
                end else if (f3[2]) begin
                    exp_need[`DIV_UNIT] = 1'b1;
                end else begin
                    exp_need[`MUL_UNIT] = 1'b1;
                end
            end
            `OPC_FENCE, `OPC_SYSTEM: begin
                exp_writes_rd = 1'b0;
            end
            default: begin
                exp_illegal = 1'b1;
                exp_writes_rd = 1'b0;
            end
        endcase
        // Store data is forwarded, so rs2 may still be pending
        exp_issue = '0;
        if (fb_valid && id_available && !issue_hold && (exp_need & unit_ready) != '0
                && !rs1_conflict && (!rs2_conflict || exp_need[`LS_UNIT])) begin
            exp_issue = exp_need;
        end
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    ////////////////////////////////
    // Compare before the edge, then advance model state
    always @(posedge clk) begin
        if (rst) begin
            exp_issue_prev <= '0;
            div_valid <= 1'b0;
        end else begin
            compare_value("rs1_addr", 64'(rs1_addr), 64'(instruction[19:15]));
            compare_value("rs2_addr", 64'(rs2_addr), 64'(instruction[24:20]));
            compare_value("unit_issue", 64'(unit_issue), 64'(exp_issue));
            compare_value("instruction_issued", 64'(instruction_issued),
                          64'(exp_issue != '0));
            compare_value("rd_write", 64'(rd_write),
                          64'((exp_issue != '0) && exp_writes_rd && instruction.r.rd != 5'd0));
            compare_value("unit_issue_r", 64'(unit_issue_r), 64'(exp_issue_prev));
            compare_value("alu_in1", 64'(alu_in1), 64'({exp_op1[31] & ~f3[0], exp_op1}));
            compare_value("alu_in2", 64'(alu_in2), 64'({exp_op2[31] & ~f3[0], exp_op2}));
            compare_value("shift_amount", 64'(shift_amount),
                          64'((opc == `OPC_ARITH) ? rs2_data[4:0] : instruction[24:20]));
            compare_value("ls_offset", 64'(ls_offset), 64'((opc == `OPC_STORE)
                          ? {instruction[31:25], instruction[11:7]} : instruction[31:20]));
            compare_value("ls_load", 64'(ls_load), 64'(opc == `OPC_LOAD));
            compare_value("ls_store", 64'(ls_store), 64'(opc == `OPC_STORE));
            compare_value("md_op", 64'(md_op), 64'(instruction[13:12]));
            compare_value("div_reuse", 64'(div_reuse), 64'(div_valid
                          && instruction.r.rs1 == div_rs1 && instruction.r.rs2 == div_rs2));
            compare_value("illegal_instruction", 64'(illegal_instruction), 64'(exp_illegal));
            exp_issue_prev <= exp_issue;
            if (exp_issue[`DIV_UNIT]) begin
                div_rs1 <= instruction.r.rs1;
                div_rs2 <= instruction.r.rs2;
                div_valid <= (instruction.r.rd != instruction.r.rs1)
                             && (instruction.r.rd != instruction.r.rs2);
            end else if (exp_issue != '0 && exp_writes_rd
                         && (instruction.r.rd == div_rs1 || instruction.r.rd == div_rs2)) begin
                div_valid <= 1'b0;
            end
        end
    end

endmodule

//--- testbench/decode_issue_sva.sv
//////////////////////////////
// Issue strobe assertions
//////////////////////////////
`include "decode_params.svh"

module decode_issue_sva (
    input logic                  clk,
    input logic                  rst,
    input logic [`NUM_UNITS-1:0] unit_issue,
    input logic [`NUM_UNITS-1:0] unit_issue_r
);

    // At most one unit takes the word
    issue_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot0(unit_issue))
        else $error("unit_issue has more than one bit set");

    issue_delayed: assert property (@(posedge clk) disable iff (rst)
        !rst |=> (unit_issue_r == $past(unit_issue)))
        else $error("unit_issue_r does not follow unit_issue by one cycle");

endmodule

bind issue_control decode_issue_sva i_sva (
    .clk(clk),
    .rst(rst),
    .unit_issue(unit_issue),
    .unit_issue_r(unit_issue_r)
);

//--- logic/decode_issue.sv
//////////////////////////////
// Decode and issue stage
//////////////////////////////
`include "decode_params.svh"

module decode_issue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fb_valid,
    input  decode_pkg::instr_word_u instruction,
    input  logic [`XLEN-1:0]        pc,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic                    rs1_conflict,
    input  logic                    rs2_conflict,
    input  logic [`NUM_UNITS-1:0]   unit_ready,
    input  logic                    id_available,
    input  logic                    issue_hold,
    output logic [4:0]              rs1_addr,
    output logic [4:0]              rs2_addr,
    output logic                    instruction_issued,
    output logic                    rd_write,
    output logic [`NUM_UNITS-1:0]   unit_issue,
    output logic [`NUM_UNITS-1:0]   unit_issue_r,
    output logic [`XLEN:0]          alu_in1,
    output logic [`XLEN:0]          alu_in2,
    output logic [4:0]              shift_amount,
    output logic [11:0]             ls_offset,
    output logic                    ls_load,
    output logic                    ls_store,
    output logic [1:0]              md_op,
    output logic                    div_reuse,
    output logic                    illegal_instruction
);

    logic [`NUM_UNITS-1:0] unit_needed;
    logic                  uses_rd;
    logic                  rd_nonzero;
    logic [1:0]            rs1_sel;
    logic [1:0]            rs2_sel;

    // Register file addresses
    assign rs1_addr = instruction.r.rs1;
    assign rs2_addr = instruction.r.rs2;
    assign rd_nonzero = |instruction.r.rd;

    instr_decoder i_decoder (
        .instruction(instruction), .unit_needed(unit_needed),
        .uses_rs1(), .uses_rs2(), .uses_rd(uses_rd),
        .rs1_sel(rs1_sel), .rs2_sel(rs2_sel),
        .ls_load(ls_load), .ls_store(ls_store),
        .illegal_instruction(illegal_instruction)
    );

    issue_control i_issue (
        .clk(clk), .rst(rst), .fb_valid(fb_valid),
        .id_available(id_available), .issue_hold(issue_hold),
        .rs1_conflict(rs1_conflict), .rs2_conflict(rs2_conflict),
        .unit_needed(unit_needed), .unit_ready(unit_ready),
        .uses_rd(uses_rd), .rd_nonzero(rd_nonzero),
        .instruction_issued(instruction_issued), .rd_write(rd_write),
        .unit_issue(unit_issue), .unit_issue_r(unit_issue_r)
    );

    div_reuse_tracker i_div_reuse (
        .clk(clk), .rst(rst), .instruction(instruction), .uses_rd(uses_rd),
        .div_needed(unit_needed[`DIV_UNIT]), .div_issue(unit_issue[`DIV_UNIT]),
        .instruction_issued(instruction_issued), .div_reuse(div_reuse)
    );

    operand_builder i_operands (
        .instruction(instruction), .pc(pc),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_sel(rs1_sel), .rs2_sel(rs2_sel),
        .alu_in1(alu_in1), .alu_in2(alu_in2), .shift_amount(shift_amount),
        .ls_offset(ls_offset), .md_op(md_op)
    );

endmodule

//--- logic/operand_builder.sv
//////////////////////////////
// Operand builder
// ALU, load/store and mul/div inputs
//////////////////////////////
`include "decode_params.svh"

module operand_builder (
    input  decode_pkg::instr_word_u instruction,
    input  logic [`XLEN-1:0]        pc,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic [1:0]              rs1_sel,
    input  logic [1:0]              rs2_sel,
    output logic [`XLEN:0]          alu_in1,
    output logic [`XLEN:0]          alu_in2,
    output logic [4:0]              shift_amount,
    output logic [11:0]             ls_offset,
    output logic [1:0]              md_op
);

    logic [`XLEN-1:0] alu_rs1_data;
    logic [`XLEN-1:0] alu_rs2_data;
    logic             signed_cmp;

    ////////////////////////////////
    // ALU operand muxes
    always_comb begin
        case (rs1_sel)
            `ALU_RS1_PC: alu_rs1_data = pc;
            `ALU_RS1_ZERO: alu_rs1_data = '0;
            default: alu_rs1_data = rs1_data;
        endcase
    end

    always_comb begin
        case (rs2_sel)
            `ALU_RS2_IMM: alu_rs2_data = {{(`XLEN-12){instruction.i.imm[11]}}, instruction.i.imm};
            `ALU_RS2_UPPER: alu_rs2_data = {instruction[31:12], 12'b0};
            `ALU_RS2_FOUR: alu_rs2_data = `XLEN'd4;
            default: alu_rs2_data = rs2_data;
        endcase
    end

    // funct3 bit 0 marks the unsigned compares
    assign signed_cmp = ~instruction.r.funct3[0];

    assign alu_in1 = {alu_rs1_data[`XLEN-1] & signed_cmp, alu_rs1_data};
    assign alu_in2 = {alu_rs2_data[`XLEN-1] & signed_cmp, alu_rs2_data};

    // Register shifts take rs2, immediate shifts the shamt field
    assign shift_amount = (instruction.r.opcode == `OPC_ARITH) ? rs2_data[4:0]
                                                                : instruction.r.rs2;

    ////////////////////////////////
    // Load/store and mul/div
    assign ls_offset = (instruction.s.opcode == `OPC_STORE)
                       ? {instruction.s.imm_hi, instruction.s.imm_lo}
                       : instruction.i.imm;

    assign md_op = instruction.r.funct3[1:0];

endmodule

//--- issue/div_reuse_tracker.sv
//////////////////////////////
// Divide reuse tracker
// Flags repeats of the last divide
//////////////////////////////
module div_reuse_tracker (
    input  logic                    clk,
    input  logic                    rst,
    input  decode_pkg::instr_word_u instruction,
    input  logic                    uses_rd,
    input  logic                    div_needed,
    input  logic                    div_issue,
    input  logic                    instruction_issued,
    output logic                    div_reuse
);

    logic [4:0] prev_rs1;
    logic [4:0] prev_rs2;
    logic       prev_valid;
    logic [4:0] watch_rs1;
    logic [4:0] watch_rs2;
    logic       clear_valid;

    always_ff @(posedge clk) begin
        if (div_issue) begin
            prev_rs1 <= instruction.r.rs1;
            prev_rs2 <= instruction.r.rs2;
        end
    end

    // A divide compares rd against its own sources
    assign watch_rs1 = div_needed ? instruction.r.rs1 : prev_rs1;
    assign watch_rs2 = div_needed ? instruction.r.rs2 : prev_rs2;
    assign clear_valid = instruction_issued & uses_rd
                         & ((instruction.r.rd == watch_rs1) | (instruction.r.rd == watch_rs2));

    // Clear has priority over set
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_valid <= 1'b0;
        end else if (clear_valid) begin
            prev_valid <= 1'b0;
        end else if (div_issue) begin
            prev_valid <= 1'b1;
        end
    end

    assign div_reuse = prev_valid & (instruction.r.rs1 == prev_rs1)
                       & (instruction.r.rs2 == prev_rs2);

endmodule

//--- issue/issue_control.sv
//////////////////////////////
// Issue control
// Per-unit issue strobes
//////////////////////////////
`include "decode_params.svh"

module issue_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fb_valid,
    input  logic                  id_available,
    input  logic                  issue_hold,
    input  logic                  rs1_conflict,
    input  logic                  rs2_conflict,
    input  logic [`NUM_UNITS-1:0] unit_needed,
    input  logic [`NUM_UNITS-1:0] unit_ready,
    input  logic                  uses_rd,
    input  logic                  rd_nonzero,
    output logic                  instruction_issued,
    output logic                  rd_write,
    output logic [`NUM_UNITS-1:0] unit_issue,
    output logic [`NUM_UNITS-1:0] unit_issue_r
);

    logic                  issue_allowed;
    logic                  operands_ready;
    logic [`NUM_UNITS-1:0] unit_operands_ready;

    assign issue_allowed = fb_valid & id_available & ~issue_hold;
    assign operands_ready = ~rs1_conflict & ~rs2_conflict;

    // Load/store forwards store data so only rs1 must be free
    always_comb begin
        unit_operands_ready = {`NUM_UNITS{operands_ready}};
        unit_operands_ready[`LS_UNIT] = ~rs1_conflict;
    end

    assign unit_issue = {`NUM_UNITS{issue_allowed}} & unit_needed & unit_ready
                        & unit_operands_ready;
    assign instruction_issued = |unit_issue;
    assign rd_write = instruction_issued & uses_rd & rd_nonzero;

    ////////////////////////////////
    // Delayed strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            unit_issue_r <= '0;
        end else begin
            unit_issue_r <= unit_issue;
        end
    end

endmodule

//--- logic/instr_decoder.sv
//////////////////////////////
// Instruction decoder
// Picks the unit and operand sources
//////////////////////////////
`include "decode_params.svh"

module instr_decoder (
    input  decode_pkg::instr_word_u  instruction,
    output logic [`NUM_UNITS-1:0]    unit_needed,
    output logic                     uses_rs1,
    output logic                     uses_rs2,
    output logic                     uses_rd,
    output logic [1:0]               rs1_sel,
    output logic [1:0]               rs2_sel,
    output logic                     ls_load,
    output logic                     ls_store,
    output logic                     illegal_instruction
);

    logic [6:0] opcode;
    logic       mul_div_op;

    assign opcode = instruction.r.opcode;
    // M extension rows carry funct7 = 0000001
    assign mul_div_op = instruction.r.funct7[0];

    always_comb begin
        unit_needed = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        uses_rd = 1'b0;
        rs1_sel = `ALU_RS1_RF;
        rs2_sel = `ALU_RS2_RF;
        illegal_instruction = 1'b0;
        case (opcode)
            `OPC_LUI, `OPC_AUIPC: begin
                unit_needed[`ALU_UNIT] = 1'b1;
                uses_rd = 1'b1;
                rs1_sel = (opcode == `OPC_LUI) ? `ALU_RS1_ZERO : `ALU_RS1_PC;
                rs2_sel = `ALU_RS2_UPPER;
            end
            `OPC_JAL, `OPC_JALR: begin
                // Link value is pc + 4
                unit_needed[`BRANCH_UNIT] = 1'b1;
                uses_rs1 = (opcode == `OPC_JALR);
                uses_rd = 1'b1;
                rs1_sel = `ALU_RS1_PC;
                rs2_sel = `ALU_RS2_FOUR;
            end
            `OPC_BRANCH: begin
                unit_needed[`BRANCH_UNIT] = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            `OPC_LOAD, `OPC_STORE: begin
                unit_needed[`LS_UNIT] = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = (opcode == `OPC_STORE);
                uses_rd = (opcode == `OPC_LOAD);
            end
            `OPC_ARITH_IMM: begin
                unit_needed[`ALU_UNIT] = 1'b1;
                uses_rs1 = 1'b1;
                uses_rd = 1'b1;
                rs2_sel = `ALU_RS2_IMM;
            end
            `OPC_ARITH: begin
                unit_needed[`ALU_UNIT] = ~mul_div_op;
                unit_needed[`MUL_UNIT] = mul_div_op & ~instruction.r.funct3[2];
                unit_needed[`DIV_UNIT] = mul_div_op & instruction.r.funct3[2];
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                uses_rd = 1'b1;
            end
            // Legal, but no unit takes them
            `OPC_FENCE, `OPC_SYSTEM: begin
                unit_needed = '0;
            end
            default: begin
                illegal_instruction = 1'b1;
            end
        endcase
    end

    assign ls_load = (opcode == `OPC_LOAD);
    assign ls_store = (opcode == `OPC_STORE);

endmodule

//--- common/decode_pkg.sv
//////////////////////////////
// Decode types
// Instruction word field views
//////////////////////////////
package decode_pkg;

    // Register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // Immediate format, also loads and JALR
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // Store format with split immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        s_fields_t s;
    } instr_word_u;

endpackage

//--- common/decode_params.svh
//////////////////////////////
// Decode stage parameters
// Widths, unit indices, opcodes
//////////////////////////////
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define XLEN      32
`define NUM_UNITS 5

// Bit positions in every unit vector
`define BRANCH_UNIT 0
`define ALU_UNIT    1
`define LS_UNIT     2
`define MUL_UNIT    3
`define DIV_UNIT    4

`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_ARITH_IMM 7'b0010011
`define OPC_ARITH     7'b0110011
`define OPC_FENCE     7'b0001111
`define OPC_SYSTEM    7'b1110011

// ALU operand select codes
`define ALU_RS1_RF    2'd0
`define ALU_RS1_PC    2'd1
`define ALU_RS1_ZERO  2'd2
`define ALU_RS2_RF    2'd0
`define ALU_RS2_IMM   2'd1
`define ALU_RS2_UPPER 2'd2
`define ALU_RS2_FOUR  2'd3

`endif
